/* vlog.f */
verilog/phy_types_pkg.sv
verilog/chiplet_types_pkg.sv
verilog/flit_crc.sv
verilog/phy_manager_tx.sv
verilog/phy_manager_rx.sv
verilog/endnode.sv
verif/endnode_checker.sv
verif/endnode_tb.sv

/* Bender.yml */
package:
  name: endnode

sources:
  - target: any(rtl, verif)
    files:
      - verilog/phy_types_pkg.sv
      - verilog/chiplet_types_pkg.sv
      - verilog/flit_crc.sv
      - verilog/phy_manager_tx.sv
      - verilog/phy_manager_rx.sv
      - verilog/endnode.sv
  - target: verif
    files:
      - verif/endnode_checker.sv
      - verif/endnode_tb.sv

/* verif/endnode_tb.sv */
`timescale 1ns/1ps

module endnode_tb;

    localparam int CYCLE_LIMIT = 4000;
    // single payload bit that leaves the header intact
    localparam logic [31:0] FLIP_MASK = 32'h0000_0100;

    logic CLK;
    logic nRST;
    logic start_tx;
    logic [31:0] flit_tx;
    logic packet_done_tx;
    logic get_data;
    logic [31:0] flit_rx;
    logic done_rx;
    logic crc_corr_rx;
    logic err_rx;
    logic resp_rx;
    phy_types_pkg::comma_sel_t resp_sel_rx;
    logic [7:0] resp_header_rx;
    logic done_tx;
    logic [33:0] data_out_tx;
    logic start_out_tx;
    phy_types_pkg::comma_sel_t comma_sel_tx_out;
    logic [33:0] enc_flit_rx;
    logic done_in_rx;
    logic err_in_rx;

    logic [31:0] lcg_state;
    int cycles;
    logic direct_mode;
    logic hold_done;
    logic kick_done;
    logic flip_arm;
    logic err_arm;
    logic err_pkt;
    logic end_seen;
    logic [2:0] done_sr;

    // scoreboard queues
    // response and link word entries hold {kind, header}
    logic [31:0] exp_flits[$];
    logic exp_crc_ok[$];
    logic [7:0] exp_end_crc[$];
    logic [10:0] exp_resp[$];
    logic [10:0] exp_tx[$];

    endnode endnode_i (.*);

    bind endnode endnode_checker checker_i (.*);

    initial CLK = 1'b0;
    always #10 CLK = ~CLK;

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // crc-8 with poly 0x07 msb first over the whole flit
    function automatic logic [7:0] ref_crc(input logic [7:0] cur, input logic [31:0] d);
        logic [7:0] c;
        logic fb;
        c = cur;
        for (int i = 31; i >= 0; i--) begin
            fb = c[7] ^ d[i];
            c = c << 1;
            if (fb) begin
                c = c ^ 8'h07;
            end
        end
        return c;
    endfunction

    task automatic stop_on_error(input string what);
        $display("%s", what);
        $display("TEST FAILED");
        $fatal(1, "simulation stopped at first error");
    endtask

    always @(posedge CLK) begin
        cycles++;
        if (endnode_i.checker_i.fail_count != 0) begin
            stop_on_error("bound checker reported a protocol assertion failure");
        end
        if (cycles > CYCLE_LIMIT) begin
            stop_on_error("timeout: traffic did not complete within the cycle limit");
        end
    end

    // serializer model that loops the link back unless in direct mode
    always @(posedge CLK) begin
        logic s_start;
        logic [33:0] s_word;
        phy_types_pkg::comma_sel_t s_sel;
        logic [7:0] exp_c;
        logic [10:0] exp_w;
        s_start = start_out_tx;
        s_word = data_out_tx;
        s_sel = comma_sel_tx_out;
        if (s_start && !direct_mode && s_sel == phy_types_pkg::END_PACKET_SEL) begin
            assert (exp_end_crc.size() != 0)
                else stop_on_error("END word launched with no packet in flight");
            exp_c = exp_end_crc.pop_front();
            assert (s_word[7:0] == exp_c)
                else stop_on_error($sformatf("Mismatch data_out_tx crc: got %h expected %h",
                    s_word[7:0], exp_c));
        end
        if (s_start && direct_mode) begin
            assert (exp_tx.size() != 0)
                else stop_on_error("link word launched with none expected");
            exp_w = exp_tx.pop_front();
            assert ({s_sel, s_word[7:0]} == exp_w)
                else stop_on_error($sformatf(
                    "Mismatch comma_sel_tx_out/data_out_tx: got %h/%h expected %h/%h",
                    s_sel, s_word[7:0], exp_w[10:8], exp_w[7:0]));
        end
        done_sr = {done_sr[1:0], s_start};
        #1;
        if (hold_done) begin
            done_tx = 1'b0;
        end else if (kick_done) begin
            done_tx = 1'b1;
            kick_done = 1'b0;
        end else begin
            done_tx = done_sr[2];
        end
        if (!direct_mode) begin
            done_in_rx = s_start;
            enc_flit_rx = s_word;
            err_in_rx = 1'b0;
            if (s_start && s_word[33:32] == phy_types_pkg::SYNC_DATA) begin
                if (flip_arm) begin
                    enc_flit_rx = s_word ^ {2'b00, FLIP_MASK};
                    flip_arm = 1'b0;
                end
                if (err_arm) begin
                    err_in_rx = 1'b1;
                    err_arm = 1'b0;
                end
            end
        end
    end

    // receive side checks
    always @(posedge CLK) begin
        logic [31:0] exp_f;
        logic exp_ok;
        logic [10:0] exp_r;
        if (nRST) begin
            if (done_rx) begin
                assert (exp_flits.size() != 0)
                    else stop_on_error("flit delivered on flit_rx with none expected");
                exp_f = exp_flits.pop_front();
                assert (flit_rx == exp_f)
                    else stop_on_error($sformatf("Mismatch flit_rx: got %h expected %h",
                        flit_rx, exp_f));
            end
            if (end_seen) begin
                assert (exp_crc_ok.size() != 0)
                    else stop_on_error("end of packet seen with no packet expected");
                exp_ok = exp_crc_ok.pop_front();
                assert (crc_corr_rx == exp_ok)
                    else stop_on_error($sformatf("Mismatch crc_corr_rx: got %h expected %h",
                        crc_corr_rx, exp_ok));
            end
            if (resp_rx) begin
                assert (exp_resp.size() != 0)
                    else stop_on_error("response reported with none expected");
                exp_r = exp_resp.pop_front();
                assert ({resp_sel_rx, resp_header_rx} == exp_r)
                    else stop_on_error($sformatf(
                        "Mismatch resp_sel_rx/resp_header_rx: got %h/%h expected %h/%h",
                        resp_sel_rx, resp_header_rx, exp_r[10:8], exp_r[7:0]));
            end
            end_seen = done_in_rx && enc_flit_rx[33:32] == phy_types_pkg::SYNC_CTRL &&
                enc_flit_rx[31:29] == phy_types_pkg::END_PACKET_SEL;
            // error flag must still hold when the end word arrives
            if (end_seen) begin
                assert (err_rx == err_pkt)
                    else stop_on_error($sformatf("Mismatch err_rx: got %h expected %h",
                        err_rx, err_pkt));
            end
        end
    end

    function automatic logic [31:0] make_flit();
        logic [31:0] r;
        chiplet_types_pkg::req_t op;
        r = lcg_next();
        op = chiplet_types_pkg::req_t'(r[1:0]);
        r[28:24] = op;
        return r;
    endfunction

    task automatic send_packet(input int n, input logic flip, input logic err);
        logic [31:0] flits [5];
        logic [7:0] crc;
        logic [7:0] hdr;
        crc = '0;
        for (int i = 0; i < n; i++) begin
            flits[i] = make_flit();
            crc = ref_crc(crc, flits[i]);
            exp_flits.push_back((flip && i == 0) ? flits[i] ^ FLIP_MASK : flits[i]);
        end
        hdr = flits[n-1][31:24];
        exp_end_crc.push_back(crc);
        exp_crc_ok.push_back(!flip);
        if (flip || err) begin
            // resend word carries only the id from header bits 6:5
            exp_resp.push_back({phy_types_pkg::RESEND_SEL, 1'b0, hdr[6:5], 5'b0});
        end else begin
            exp_resp.push_back({phy_types_pkg::ACK_SEL, hdr});
        end
        @(posedge CLK);
        flip_arm = flip;
        err_arm = err;
        err_pkt = err;
        #1;
        start_tx = 1'b1;
        flit_tx = flits[0];
        packet_done_tx = (n == 1);
        @(posedge CLK);
        #1;
        start_tx = 1'b0;
        for (int i = 0; i < n; i++) begin
            do @(posedge CLK); while (!get_data);
            #1;
            if (i + 1 < n) begin
                flit_tx = flits[i+1];
                packet_done_tx = (i + 1 == n - 1);
            end else begin
                flit_tx = '0;
                packet_done_tx = 1'b0;
            end
        end
        while (exp_resp.size() != 0 || exp_flits.size() != 0 || exp_crc_ok.size() != 0) begin
            @(posedge CLK);
        end
    endtask

    task automatic inject_word(input logic [33:0] w);
        @(posedge CLK);
        #1;
        enc_flit_rx = w;
        done_in_rx = 1'b1;
        @(posedge CLK);
        #1;
        done_in_rx = 1'b0;
    endtask

    task automatic run_direct();
        logic [31:0] f [4];
        logic [7:0] h [4];
        for (int i = 0; i < 4; i++) begin
            f[i] = make_flit();
            h[i] = f[i][31:24];
            exp_flits.push_back(f[i]);
            exp_crc_ok.push_back(1'b1);
        end
        // first ack takes the idle link and the rest wait behind the held done_tx
        exp_tx.push_back({phy_types_pkg::ACK_SEL, h[0]});
        exp_tx.push_back({phy_types_pkg::NACK_SEL, h[3]});
        exp_tx.push_back({phy_types_pkg::ACK_SEL, h[1]});
        exp_tx.push_back({phy_types_pkg::ACK_SEL, h[2]});
        repeat (6) @(posedge CLK);
        direct_mode = 1'b1;
        hold_done = 1'b1;
        err_pkt = 1'b0;
        for (int i = 0; i < 4; i++) begin
            inject_word({phy_types_pkg::SYNC_DATA, f[i]});
            inject_word({phy_types_pkg::SYNC_CTRL, phy_types_pkg::END_PACKET_SEL,
                {phy_types_pkg::CTRL_PAD_WIDTH{1'b0}}, ref_crc(8'h00, f[i])});
            repeat (3) @(posedge CLK);
        end
        assert (exp_tx.size() == 3)
            else stop_on_error("wrong number of link words launched while done_tx was held");
        @(posedge CLK);
        hold_done = 1'b0;
        kick_done = 1'b1;
        while (exp_tx.size() != 0 || exp_flits.size() != 0) begin
            @(posedge CLK);
        end
        repeat (5) @(posedge CLK);
    endtask

    initial begin
        lcg_state = 32'h4006e090;
        cycles = 0;
        direct_mode = 1'b0;
        hold_done = 1'b0;
        kick_done = 1'b0;
        flip_arm = 1'b0;
        err_arm = 1'b0;
        err_pkt = 1'b0;
        end_seen = 1'b0;
        done_sr = '0;
        nRST = 1'b0;
        start_tx = 1'b0;
        flit_tx = '0;
        packet_done_tx = 1'b0;
        done_tx = 1'b0;
        enc_flit_rx = '0;
        done_in_rx = 1'b0;
        err_in_rx = 1'b0;
        repeat (5) @(posedge CLK);
        #1;
        nRST = 1'b1;
        assert (crc_corr_rx && !err_rx && !start_out_tx && !get_data && !done_rx && !resp_rx)
            else stop_on_error("outputs not at their reset values after reset");

        // clean looped packets acked with their last header
        for (int p = 0; p < 8; p++) begin
            send_packet(int'(lcg_next() % 32'd5) + 1, 1'b0, 1'b0);
        end
        // corrupted data word
        send_packet(3, 1'b1, 1'b0);
        send_packet(1, 1'b1, 1'b0);
        // line error with a good crc
        send_packet(4, 1'b0, 1'b1);
        send_packet(2, 1'b0, 1'b0);
        run_direct();

        if (endnode_i.checker_i.fail_count != 0) begin
            stop_on_error("bound checker reported a protocol assertion failure");
        end else begin
            $display("TEST PASSED");
            $finish;
        end
    end

endmodule

/* verif/endnode_checker.sv */
`timescale 1ns/1ps

module endnode_checker (
    input logic                                 CLK,
    input logic                                 nRST,
    input logic                                 start_out_tx,
    input logic                                 done_tx,
    input logic                                 get_data,
    input phy_types_pkg::comma_sel_t            comma_sel_tx_out,
    input logic [phy_types_pkg::ENC_WIDTH-1:0]  enc_flit_rx,
    input logic                                 done_in_rx,
    input logic                                 done_rx,
    input logic                                 resp_rx,
    input logic                                 err_rx
);

    logic link_busy;
    // count of failed assertions
    int fail_count = 0;

    // word on the wire until the serializer reports done
    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            link_busy <= 1'b0;
        end else if (start_out_tx) begin
            link_busy <= 1'b1;
        end else if (done_tx) begin
            link_busy <= 1'b0;
        end
    end

    single_launch: assert property (@(posedge CLK) disable iff (!nRST)
        start_out_tx |-> !link_busy)
        else begin
            fail_count++;
            $error("start_out_tx fired again before done_tx");
        end

    pull_on_data: assert property (@(posedge CLK) disable iff (!nRST)
        get_data |-> (start_out_tx && comma_sel_tx_out == phy_types_pkg::DATA_SEL))
        else begin
            fail_count++;
            $error("get_data without a data word launch");
        end

    rx_latency: assert property (@(posedge CLK) disable iff (!nRST)
        (done_in_rx && enc_flit_rx[33:32] == phy_types_pkg::SYNC_DATA) |=> done_rx)
        else begin
            fail_count++;
            $error("done_rx missing one cycle after a data word");
        end

    // outputs quiet while reset is held
    reset_quiet: assert property (@(posedge CLK)
        !nRST |-> !(start_out_tx || get_data || done_rx || resp_rx || err_rx))
        else begin
            fail_count++;
            $error("control output active during reset");
        end

endmodule

/* verilog/endnode.sv */
`timescale 1ns/1ps

module endnode (
    input  logic                                            CLK,
    input  logic                                            nRST,
    // switch side
    input  logic                                            start_tx,
    input  logic [chiplet_types_pkg::FLIT_WIDTH-1:0]        flit_tx,
    input  logic                                            packet_done_tx,
    output logic                                            get_data,
    output logic [chiplet_types_pkg::FLIT_WIDTH-1:0]        flit_rx,
    output logic                                            done_rx,
    output logic                                            crc_corr_rx,
    output logic                                            err_rx,
    output logic                                            resp_rx,
    output phy_types_pkg::comma_sel_t                       resp_sel_rx,
    output logic [chiplet_types_pkg::HEADER_WIDTH-1:0]      resp_header_rx,
    // link side
    input  logic                                            done_tx,
    output logic [phy_types_pkg::ENC_WIDTH-1:0]             data_out_tx,
    output logic                                            start_out_tx,
    output phy_types_pkg::comma_sel_t                       comma_sel_tx_out,
    input  logic [phy_types_pkg::ENC_WIDTH-1:0]             enc_flit_rx,
    input  logic                                            done_in_rx,
    input  logic                                            err_in_rx
);

    logic err_store;
    logic err_out;
    logic packet_done;
    logic [chiplet_types_pkg::HEADER_WIDTH-1:0] rx_header;
    logic ack_full;
    logic pkt_good;
    logic ack_write;
    logic nack_write;
    logic resend_write;
    logic [chiplet_types_pkg::ID_WIDTH-1:0] resend_id;

    // sticky line error for the packet in flight
    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            err_store <= 1'b0;
        end else if (packet_done) begin
            err_store <= 1'b0;
        end else if (err_out) begin
            err_store <= 1'b1;
        end
    end

    assign err_rx = err_store;

    // err_out can land in the same cycle as packet_done
    assign pkt_good = crc_corr_rx && !err_store && !err_out;
    assign ack_write = packet_done && pkt_good && !ack_full;
    assign nack_write = packet_done && pkt_good && ack_full;
    assign resend_write = packet_done && !pkt_good;
    assign resend_id = rx_header[chiplet_types_pkg::HDR_ID_MSB -: chiplet_types_pkg::ID_WIDTH];

    phy_manager_tx phy_tx (
        .CLK              (CLK),
        .nRST             (nRST),
        .done_tx          (done_tx),
        .start_tx         (start_tx),
        .flit_tx          (flit_tx),
        .packet_done_tx   (packet_done_tx),
        .ack_write        (ack_write),
        .nack_write       (nack_write),
        .resend_write     (resend_write),
        .resend_id        (resend_id),
        .rx_header        (rx_header),
        .get_data         (get_data),
        .data_out_tx      (data_out_tx),
        .start_out_tx     (start_out_tx),
        .comma_sel_tx_out (comma_sel_tx_out),
        .ack_full         (ack_full)
    );

    phy_manager_rx phy_rx (
        .CLK            (CLK),
        .nRST           (nRST),
        .enc_flit_rx    (enc_flit_rx),
        .done_in_rx     (done_in_rx),
        .err_in_rx      (err_in_rx),
        .flit_rx        (flit_rx),
        .done_rx        (done_rx),
        .crc_corr_rx    (crc_corr_rx),
        .err_out        (err_out),
        .packet_done    (packet_done),
        .rx_header      (rx_header),
        .resp_rx        (resp_rx),
        .resp_sel_rx    (resp_sel_rx),
        .resp_header_rx (resp_header_rx)
    );

endmodule

/* verilog/phy_manager_rx.sv */
`timescale 1ns/1ps

module phy_manager_rx (
    input  logic                                            CLK,
    input  logic                                            nRST,
    input  logic [phy_types_pkg::ENC_WIDTH-1:0]             enc_flit_rx,
    input  logic                                            done_in_rx,
    input  logic                                            err_in_rx,
    output logic [chiplet_types_pkg::FLIT_WIDTH-1:0]        flit_rx,
    output logic                                            done_rx,
    output logic                                            crc_corr_rx,
    output logic                                            err_out,
    output logic                                            packet_done,
    output logic [chiplet_types_pkg::HEADER_WIDTH-1:0]      rx_header,
    output logic                                            resp_rx,
    output phy_types_pkg::comma_sel_t                       resp_sel_rx,
    output logic [chiplet_types_pkg::HEADER_WIDTH-1:0]      resp_header_rx
);

    logic [phy_types_pkg::SYNC_WIDTH-1:0] sync;
    logic [chiplet_types_pkg::FLIT_WIDTH-1:0] word;
    phy_types_pkg::comma_sel_t code;
    logic [phy_types_pkg::CRC_WIDTH-1:0] field;
    logic [phy_types_pkg::CRC_WIDTH-1:0] crc;

    logic is_data;
    logic is_end;
    logic is_resp;
    logic bad_word;

    // word split
    assign sync = enc_flit_rx[phy_types_pkg::ENC_WIDTH-1 -: phy_types_pkg::SYNC_WIDTH];
    assign word = enc_flit_rx[chiplet_types_pkg::FLIT_WIDTH-1:0];
    assign code = phy_types_pkg::comma_sel_t'(
        word[chiplet_types_pkg::FLIT_WIDTH-1 -: phy_types_pkg::CODE_WIDTH]);
    assign field = word[phy_types_pkg::CRC_WIDTH-1:0];

    // word kind from sync header and code
    always_comb begin
        is_data = 1'b0;
        is_end = 1'b0;
        is_resp = 1'b0;
        bad_word = 1'b0;
        if (done_in_rx) begin
            if (sync == phy_types_pkg::SYNC_DATA) begin
                is_data = 1'b1;
            end else if (sync == phy_types_pkg::SYNC_CTRL) begin
                case (code)
                    phy_types_pkg::END_PACKET_SEL: is_end = 1'b1;
                    phy_types_pkg::ACK_SEL,
                    phy_types_pkg::NACK_SEL,
                    phy_types_pkg::RESEND_SEL: is_resp = 1'b1;
                    // unknown control code counts as a line error
                    default: bad_word = 1'b1;
                endcase
            end else begin
                bad_word = 1'b1;
            end
        end
    end

    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            done_rx <= 1'b0;
            packet_done <= 1'b0;
            resp_rx <= 1'b0;
            err_out <= 1'b0;
            crc_corr_rx <= 1'b1;
        end else begin
            done_rx <= is_data;
            packet_done <= is_end;
            resp_rx <= is_resp;
            err_out <= done_in_rx && (err_in_rx || bad_word);
            if (is_end) begin
                crc_corr_rx <= (field == crc);
            end
        end
    end

    always_ff @(posedge CLK) begin
        if (is_data) begin
            flit_rx <= word;
            rx_header <= word[chiplet_types_pkg::FLIT_WIDTH-1 -: chiplet_types_pkg::HEADER_WIDTH];
        end
        if (is_resp) begin
            resp_sel_rx <= code;
            resp_header_rx <= field;
        end
    end

    // accumulated over data words only, restarts after each end word
    flit_crc crc_i (
        .CLK    (CLK),
        .nRST   (nRST),
        .clear  (is_end),
        .update (is_data),
        .data   (word),
        .crc    (crc)
    );

endmodule

/* verilog/phy_manager_tx.sv */
`timescale 1ns/1ps

module phy_manager_tx (
    input  logic                                            CLK,
    input  logic                                            nRST,
    input  logic                                            done_tx,
    input  logic                                            start_tx,
    input  logic [chiplet_types_pkg::FLIT_WIDTH-1:0]        flit_tx,
    input  logic                                            packet_done_tx,
    input  logic                                            ack_write,
    input  logic                                            nack_write,
    input  logic                                            resend_write,
    input  logic [chiplet_types_pkg::ID_WIDTH-1:0]          resend_id,
    input  logic [chiplet_types_pkg::HEADER_WIDTH-1:0]      rx_header,
    output logic                                            get_data,
    output logic [phy_types_pkg::ENC_WIDTH-1:0]             data_out_tx,
    output logic                                            start_out_tx,
    output phy_types_pkg::comma_sel_t                       comma_sel_tx_out,
    output logic                                            ack_full
);

    phy_types_pkg::tx_state_t state, next_state;
    phy_types_pkg::comma_sel_t sel;

    logic link_ready;
    logic launch;
    logic [phy_types_pkg::CRC_WIDTH-1:0] field;
    logic [phy_types_pkg::CRC_WIDTH-1:0] crc;

    // response stores
    logic [chiplet_types_pkg::ID_COUNT-1:0] resend_pend;
    logic [chiplet_types_pkg::ID_COUNT-1:0] resend_set;
    logic [chiplet_types_pkg::ID_COUNT-1:0] resend_clr;
    logic rs_hit;
    logic [chiplet_types_pkg::ID_WIDTH-1:0] rs_idx;
    logic nack_pend;
    logic [chiplet_types_pkg::HEADER_WIDTH-1:0] nack_hdr;

    logic [chiplet_types_pkg::HEADER_WIDTH-1:0] ack_mem [chiplet_types_pkg::ACK_DEPTH];
    logic [chiplet_types_pkg::ACK_PTR_WIDTH-1:0] ack_wr, ack_rd;
    logic [chiplet_types_pkg::ACK_CNT_WIDTH-1:0] ack_count;
    logic ack_push, ack_pop;

    // lowest pending id wins
    always_comb begin
        rs_hit = 1'b0;
        rs_idx = '0;
        for (int i = chiplet_types_pkg::ID_COUNT - 1; i >= 0; i--) begin
            if (resend_pend[i]) begin
                rs_hit = 1'b1;
                rs_idx = chiplet_types_pkg::ID_WIDTH'(i);
            end
        end
    end

    // launch arbitration: resend, nack, ack, then packet traffic
    always_comb begin
        launch = 1'b0;
        sel = phy_types_pkg::DATA_SEL;
        field = '0;
        if (link_ready) begin
            if (rs_hit) begin
                launch = 1'b1;
                sel = phy_types_pkg::RESEND_SEL;
                field[chiplet_types_pkg::HDR_ID_MSB -: chiplet_types_pkg::ID_WIDTH] = rs_idx;
            end else if (nack_pend) begin
                launch = 1'b1;
                sel = phy_types_pkg::NACK_SEL;
                field = nack_hdr;
            end else if (ack_count != '0) begin
                launch = 1'b1;
                sel = phy_types_pkg::ACK_SEL;
                field = ack_mem[ack_rd];
            end else if (state == phy_types_pkg::TX_DATA) begin
                launch = 1'b1;
                sel = phy_types_pkg::DATA_SEL;
            end else if (state == phy_types_pkg::TX_END) begin
                launch = 1'b1;
                sel = phy_types_pkg::END_PACKET_SEL;
                field = crc;
            end
        end
    end

    assign start_out_tx = launch;
    assign comma_sel_tx_out = sel;
    assign get_data = launch && (sel == phy_types_pkg::DATA_SEL);
    assign data_out_tx = (sel == phy_types_pkg::DATA_SEL) ?
        {phy_types_pkg::SYNC_DATA, flit_tx} :
        {phy_types_pkg::SYNC_CTRL, sel, {phy_types_pkg::CTRL_PAD_WIDTH{1'b0}}, field};

    always_comb begin
        next_state = state;
        case (state)
            phy_types_pkg::TX_IDLE: begin
                if (start_tx) begin
                    next_state = phy_types_pkg::TX_DATA;
                end
            end
            phy_types_pkg::TX_DATA: begin
                if (get_data && packet_done_tx) begin
                    next_state = phy_types_pkg::TX_END;
                end
            end
            phy_types_pkg::TX_END: begin
                if (launch && sel == phy_types_pkg::END_PACKET_SEL) begin
                    next_state = phy_types_pkg::TX_IDLE;
                end
            end
            default: next_state = phy_types_pkg::TX_IDLE;
        endcase
    end

    assign ack_full = (ack_count == chiplet_types_pkg::ACK_DEPTH);
    assign ack_push = ack_write && !ack_full;
    assign ack_pop = launch && (sel == phy_types_pkg::ACK_SEL);

    // a new request for an id outlives the launch of the old one
    assign resend_set = resend_write ? (chiplet_types_pkg::ID_COUNT'(1) << resend_id) : '0;
    assign resend_clr = (launch && sel == phy_types_pkg::RESEND_SEL) ?
        (chiplet_types_pkg::ID_COUNT'(1) << rs_idx) : '0;

    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            state <= phy_types_pkg::TX_IDLE;
            link_ready <= 1'b1;
            resend_pend <= '0;
            nack_pend <= 1'b0;
            ack_wr <= '0;
            ack_rd <= '0;
            ack_count <= '0;
        end else begin
            state <= next_state;
            if (launch) begin
                link_ready <= 1'b0;
            end else if (done_tx) begin
                link_ready <= 1'b1;
            end
            resend_pend <= (resend_pend & ~resend_clr) | resend_set;
            if (nack_write) begin
                nack_pend <= 1'b1;
            end else if (launch && sel == phy_types_pkg::NACK_SEL) begin
                nack_pend <= 1'b0;
            end
            if (ack_push) begin
                ack_wr <= ack_wr + 1'b1;
            end
            if (ack_pop) begin
                ack_rd <= ack_rd + 1'b1;
            end
            ack_count <= ack_count + ack_push - ack_pop;
        end
    end

    always_ff @(posedge CLK) begin
        if (nack_write) begin
            nack_hdr <= rx_header;
        end
        if (ack_push) begin
            ack_mem[ack_wr] <= rx_header;
        end
    end

    // control words stay out of the packet crc
    flit_crc crc_i (
        .CLK    (CLK),
        .nRST   (nRST),
        .clear  (launch && sel == phy_types_pkg::END_PACKET_SEL),
        .update (get_data),
        .data   (flit_tx),
        .crc    (crc)
    );

endmodule

/* verilog/flit_crc.sv */
`timescale 1ns/1ps

module flit_crc (
    input  logic                                        CLK,
    input  logic                                        nRST,
    input  logic                                        clear,
    input  logic                                        update,
    input  logic [chiplet_types_pkg::FLIT_WIDTH-1:0]    data,
    output logic [phy_types_pkg::CRC_WIDTH-1:0]         crc
);

    logic [phy_types_pkg::CRC_WIDTH-1:0] crc_next;

    // one whole flit folded in, msb first
    function automatic logic [phy_types_pkg::CRC_WIDTH-1:0] crc_step(
        input logic [phy_types_pkg::CRC_WIDTH-1:0] cur,
        input logic [chiplet_types_pkg::FLIT_WIDTH-1:0] d
    );
        logic [phy_types_pkg::CRC_WIDTH-1:0] r;
        r = cur;
        for (int i = chiplet_types_pkg::FLIT_WIDTH - 1; i >= 0; i--) begin
            if (r[phy_types_pkg::CRC_WIDTH-1] ^ d[i]) begin
                r = {r[phy_types_pkg::CRC_WIDTH-2:0], 1'b0} ^ phy_types_pkg::CRC_POLY;
            end else begin
                r = {r[phy_types_pkg::CRC_WIDTH-2:0], 1'b0};
            end
        end
        return r;
    endfunction

    assign crc_next = crc_step(crc, data);

    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            crc <= '0;
        end else if (clear) begin
            crc <= '0;
        end else if (update) begin
            crc <= crc_next;
        end
    end

endmodule

/* verilog/chiplet_types_pkg.sv */
package chiplet_types_pkg;

    localparam int FLIT_WIDTH = 32;

    // flit header fields, top of the flit
    localparam int VC_BIT = 31;
    localparam int ID_MSB = 30;
    localparam int ID_LSB = 29;
    localparam int REQ_MSB = 28;
    localparam int REQ_LSB = 24;

    localparam int ID_WIDTH = ID_MSB - ID_LSB + 1;
    localparam int REQ_WIDTH = REQ_MSB - REQ_LSB + 1;

    // vc, id and req together, echoed in response words
    localparam int HEADER_WIDTH = 8;
    localparam int PAYLOAD_WIDTH = FLIT_WIDTH - HEADER_WIDTH;

    // id field position inside an 8-bit header
    localparam int HDR_ID_MSB = ID_MSB - PAYLOAD_WIDTH;

    // request opcodes in the req field
    typedef enum logic [REQ_WIDTH-1:0] {
        REQ_READ,
        REQ_WRITE,
        REQ_RESP,
        REQ_MSG
    } req_t;

    // ids that can be asked to resend
    localparam int ID_COUNT = 4;

    // headers waiting for an ack word on the transmit side
    localparam int ACK_DEPTH = 2;

    localparam int ACK_PTR_WIDTH = (ACK_DEPTH > 1) ? $clog2(ACK_DEPTH) : 1;
    localparam int ACK_CNT_WIDTH = $clog2(ACK_DEPTH + 1);

endpackage

/* verilog/phy_types_pkg.sv */
package phy_types_pkg;

    // encoded link word: sync header on top, 32 data bits below
    localparam int ENC_WIDTH = 34;
    localparam int SYNC_WIDTH = 2;

    localparam logic [SYNC_WIDTH-1:0] SYNC_DATA = 2'b01;
    localparam logic [SYNC_WIDTH-1:0] SYNC_CTRL = 2'b10;

    // control word layout: kind code in the top data bits, 8-bit field at the bottom
    localparam int CODE_WIDTH = 3;
    localparam int CRC_WIDTH = 8;
    localparam int CTRL_PAD_WIDTH = ENC_WIDTH - SYNC_WIDTH - CODE_WIDTH - CRC_WIDTH;

    // crc-8, msb first
    localparam logic [CRC_WIDTH-1:0] CRC_POLY = 8'h07;

    // word kind, also the code carried by control words
    typedef enum logic [CODE_WIDTH-1:0] {
        DATA_SEL,
        END_PACKET_SEL,
        ACK_SEL,
        NACK_SEL,
        RESEND_SEL
    } comma_sel_t;

    // transmit packet sequencing
    typedef enum logic [1:0] {
        TX_IDLE,
        TX_DATA,
        TX_END
    } tx_state_t;

endpackage
